/* hw/spidergon_pkg.sv */
// shared flit, link and port types for the spidergon NoC, imported by every RTL module
`default_nettype none

package spidergon_pkg;

	// largest ring the address field can cover
	localparam int max_nodes = 16;
	localparam int addr_width = $clog2(max_nodes);
	localparam int data_width = 16;

	// anticlockwise, clockwise, across and local
	localparam int num_ports = 4;

	typedef logic [addr_width-1:0] node_addr_t;

	// one flit is a whole packet
	typedef struct packed {
		node_addr_t dest;
		node_addr_t src;
		logic [data_width-1:0] payload;
	} flit_t;

	// one direction of a valid/ready link, ready travels back separately
	typedef struct packed {
		logic valid;
		flit_t flit;
	} link_t;

	typedef enum logic [1:0] {
		port_anticlockwise = 2'd0,
		port_clockwise = 2'd1,
		port_across = 2'd2,
		port_local = 2'd3
	} port_e;

	// one bit per router port
	typedef logic [num_ports-1:0] port_vec_t;

endpackage

`default_nettype wire

/* hw/output_link.sv */
// output register of a router port, holding a granted flit until downstream takes it
`timescale 1ns/1ps
`default_nettype none

module output_link (
	input wire logic clk,
	input wire logic reset,
	input wire logic load,
	input wire spidergon_pkg::flit_t flit_in,
	output spidergon_pkg::link_t out_link,
	input wire logic out_ready,
	output logic ready
);

	import spidergon_pkg::*;

	logic valid_q;
	flit_t flit_q;

	// free now, or free after this edge's handshake
	assign ready = !valid_q || out_ready;
	assign out_link = {valid_q, flit_q};

	always_ff @(posedge clk)
	begin
		if (reset)
			valid_q <= 1'b0;
		else if (load)
			valid_q <= 1'b1;
		else if (out_ready)
			valid_q <= 1'b0;
	end

	// a load on the accept edge replaces the outgoing flit
	always_ff @(posedge clk)
	begin
		if (load)
			flit_q <= flit_in;
	end

endmodule

`default_nettype wire

/* hw/output_arbiter.sv */
// round-robin arbiter that picks one input slot for an output port each cycle
`timescale 1ns/1ps
`default_nettype none

module output_arbiter (
	input wire logic clk,
	input wire logic reset,
	input wire spidergon_pkg::port_vec_t request,
	input wire logic link_ready,
	output spidergon_pkg::port_vec_t grant
);

	import spidergon_pkg::*;

	// first input to look at in the next search
	logic [1:0] pointer;
	logic [1:0] candidate;
	logic [1:0] winner;
	logic found;

	// search from the pointer upward, wrapping through all four inputs
	always_comb
	begin
		grant = '0;
		winner = pointer;
		found = 1'b0;
		candidate = pointer;
		for (int k = 0; k < num_ports; k++)
		begin
			candidate = pointer + 2'(k);
			if (link_ready && !found && request[candidate])
			begin
				grant[candidate] = 1'b1;
				winner = candidate;
				found = 1'b1;
			end
		end
	end

	// the winner drops to lowest priority next time
	always_ff @(posedge clk)
	begin
		if (reset)
			pointer <= 2'(port_anticlockwise);
		else if (found)
			pointer <= winner + 2'd1;
	end

endmodule

`default_nettype wire

/* hw/input_slot.sv */
// one-flit router input buffer; routes the flit on capture and requests its output port
`timescale 1ns/1ps
`default_nettype none

module input_slot #(
	parameter int num_nodes = 8,
	parameter int node_id = 0
) (
	input wire logic clk,
	input wire logic reset,
	input wire spidergon_pkg::link_t in_link,
	output logic ready,
	input wire logic grant,
	output spidergon_pkg::port_vec_t request,
	output spidergon_pkg::flit_t flit
);

	import spidergon_pkg::*;

	localparam int rel_width = addr_width + 1;
	// ring distance still handled on the ring, anything further goes across first
	localparam int quarter = num_nodes / 4;

	logic full;
	logic capture;
	logic [rel_width-1:0] rel_sum;
	logic [rel_width-1:0] rel;
	port_e route;
	port_e port_q;

	// ready is just the registered empty flag
	assign ready = !full;
	assign capture = in_link.valid && !full;

	// rel = (dest - node_id) mod num_nodes, dest is always below num_nodes
	always_comb
	begin
		rel_sum = {1'b0, in_link.flit.dest} + rel_width'(num_nodes - node_id);
		if (rel_sum >= rel_width'(num_nodes))
			rel = rel_sum - rel_width'(num_nodes);
		else
			rel = rel_sum;

		if (rel == '0)
			route = port_local;
		else if (rel <= quarter)
			route = port_clockwise;
		else if (rel >= num_nodes - quarter)
			route = port_anticlockwise;
		else
			route = port_across;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			full <= 1'b0;
		else if (capture)
			full <= 1'b1;
		else if (grant)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			flit <= in_link.flit;
			port_q <= route;
		end
	end

	always_comb
	begin
		request = '0;
		if (full)
			request[port_q] = 1'b1;
	end

endmodule

`default_nettype wire

/* hw/spidergon_router.sv */
// one spidergon node: input slots, round-robin output arbiters and output link registers
`timescale 1ns/1ps
`default_nettype none

module spidergon_router #(
	parameter int num_nodes = 8,
	parameter int node_id = 0
) (
	input wire logic clk,
	input wire logic reset,
	input wire spidergon_pkg::link_t [spidergon_pkg::num_ports-1:0] in_link,
	output wire spidergon_pkg::port_vec_t in_ready,
	output wire spidergon_pkg::link_t [spidergon_pkg::num_ports-1:0] out_link,
	input wire spidergon_pkg::port_vec_t out_ready
);

	import spidergon_pkg::*;

	// slot side, indexed by input port
	wire port_vec_t slot_request [num_ports];
	wire flit_t slot_flit [num_ports];
	port_vec_t slot_grant;

	// output side, indexed by output port; bit i of each vector is input slot i
	port_vec_t arb_request [num_ports];
	wire port_vec_t arb_grant [num_ports];
	wire port_vec_t link_ready;
	port_vec_t link_load;
	flit_t link_flit [num_ports];

	// transpose the request matrix so each arbiter sees one column
	always_comb
	begin
		for (int o = 0; o < num_ports; o++)
		begin
			for (int i = 0; i < num_ports; i++)
				arb_request[o][i] = slot_request[i][o];
		end
	end

	// grants release the slots and steer the winning flit into its output register
	always_comb
	begin
		slot_grant = '0;
		for (int o = 0; o < num_ports; o++)
		begin
			link_load[o] = |arb_grant[o];
			link_flit[o] = '0;
			for (int i = 0; i < num_ports; i++)
			begin
				if (arb_grant[o][i])
				begin
					slot_grant[i] = 1'b1;
					link_flit[o] = link_flit[o] | slot_flit[i];
				end
			end
		end
	end

	genvar p;

	generate
		for (p = 0; p < num_ports; p++)
		begin : g_port
			input_slot #(
				.num_nodes(num_nodes),
				.node_id(node_id)
			) u_slot (
				.clk(clk),
				.reset(reset),
				.in_link(in_link[p]),
				.ready(in_ready[p]),
				.grant(slot_grant[p]),
				.request(slot_request[p]),
				.flit(slot_flit[p])
			);

			output_arbiter u_arbiter (
				.clk(clk),
				.reset(reset),
				.request(arb_request[p]),
				.link_ready(link_ready[p]),
				.grant(arb_grant[p])
			);

			output_link u_link (
				.clk(clk),
				.reset(reset),
				.load(link_load[p]),
				.flit_in(link_flit[p]),
				.out_link(out_link[p]),
				.out_ready(out_ready[p]),
				.ready(link_ready[p])
			);
		end
	endgenerate

endmodule

`default_nettype wire

/* hw/spidergon_top.sv */
// spidergon NoC top level: instantiate num_nodes routers and wire ring, across and local links
`timescale 1ns/1ps
`default_nettype none

module spidergon_top #(
	parameter int num_nodes = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire spidergon_pkg::link_t [num_nodes-1:0] inject_link,
	output wire logic [num_nodes-1:0] inject_ready,
	output wire spidergon_pkg::link_t [num_nodes-1:0] eject_link,
	input wire logic [num_nodes-1:0] eject_ready
);

	import spidergon_pkg::*;

	// per node view of the four links, indexed by port_e
	wire link_t [num_ports-1:0] node_in_link [num_nodes];
	wire link_t [num_ports-1:0] node_out_link [num_nodes];
	wire port_vec_t node_in_ready [num_nodes];
	wire port_vec_t node_out_ready [num_nodes];

	genvar n;

	generate
		for (n = 0; n < num_nodes; n++)
		begin : g_node
			localparam int next_node = (n + 1) % num_nodes;
			localparam int prev_node = (n + num_nodes - 1) % num_nodes;
			localparam int opposite_node = (n + num_nodes / 2) % num_nodes;

			// anticlockwise input comes from the clockwise output of the previous node
			assign node_in_link[n][port_anticlockwise] = node_out_link[prev_node][port_clockwise];
			assign node_out_ready[prev_node][port_clockwise] = node_in_ready[n][port_anticlockwise];

			// clockwise input comes from the anticlockwise output of the next node
			assign node_in_link[n][port_clockwise] = node_out_link[next_node][port_anticlockwise];
			assign node_out_ready[next_node][port_anticlockwise] = node_in_ready[n][port_clockwise];

			// across links pair node n with the node half a ring away
			assign node_in_link[n][port_across] = node_out_link[opposite_node][port_across];
			assign node_out_ready[opposite_node][port_across] = node_in_ready[n][port_across];

			// local port faces the outside world
			assign node_in_link[n][port_local] = inject_link[n];
			assign inject_ready[n] = node_in_ready[n][port_local];
			assign eject_link[n] = node_out_link[n][port_local];
			assign node_out_ready[n][port_local] = eject_ready[n];

			spidergon_router #(
				.num_nodes(num_nodes),
				.node_id(n)
			) u_router (
				.clk(clk),
				.reset(reset),
				.in_link(node_in_link[n]),
				.in_ready(node_in_ready[n]),
				.out_link(node_out_link[n]),
				.out_ready(node_out_ready[n])
			);
		end
	endgenerate

endmodule

`default_nettype wire

/* tests/spidergon_checks.svh */
// testbench helpers included into spidergon_tb: payload LFSR, hop reference and compare tasks

// fibonacci LFSR with taps 32 22 2 1, one step per payload bit
function automatic logic [data_width-1:0] random_payload();
	logic [data_width-1:0] bits;
	for (int b = 0; b < data_width; b++)
	begin
		lfsr_state = {lfsr_state[30:0],
			lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
		bits[b] = lfsr_state[0];
	end
	return bits;
endfunction

// walk the across-first rule node by node and count the links taken
function automatic int hop_count(input int src, input int dest);
	int node;
	int rel;
	int hops;
	node = src;
	hops = 0;
	while (node != dest)
	begin
		rel = (dest - node + num_nodes) % num_nodes;
		if (rel <= num_nodes / 4)
			node = (node + 1) % num_nodes;
		else if (rel >= num_nodes - num_nodes / 4)
			node = (node + num_nodes - 1) % num_nodes;
		else
			node = (node + num_nodes / 2) % num_nodes;
		hops++;
	end
	return hops;
endfunction

task automatic compare_flit(input flit_t got, input flit_t expected, input string what);
	if (got !== expected)
	begin
		mismatch_count++;
		$display("mismatch at %0t: %s got %h expected %h", $time, what, got, expected);
	end
endtask

task automatic compare_count(input integer got, input integer expected, input string what);
	if (got !== expected)
	begin
		mismatch_count++;
		$display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, expected);
	end
endtask

/* tests/spidergon_tb.sv */
// testbench for spidergon_top: directed routing, latency, traffic and back-pressure tests
`timescale 1ns/1ps
`default_nettype none

module spidergon_tb;

	import spidergon_pkg::*;

	localparam int num_nodes = 8;
	// all tests together need a few hundred cycles
	localparam int watchdog_cycles = 6000;

	logic clk = 1'b0;
	logic reset;
	link_t [num_nodes-1:0] inject_link;
	wire logic [num_nodes-1:0] inject_ready;
	wire link_t [num_nodes-1:0] eject_link;
	logic [num_nodes-1:0] eject_ready;

	int cycle = 0;
	logic [31:0] lfsr_state = 32'hbba5ca45;
	int mismatch_count = 0;
	int fail_count = 0;
	int accept_cycle [num_nodes];
	flit_t sent [num_nodes];
	// deliveries seen by the monitor
	flit_t got_flit [$];
	int got_node [$];
	int got_cycle [$];

	`include "spidergon_checks.svh"

	spidergon_top #(
		.num_nodes(num_nodes)
	) uut (
		.clk(clk),
		.reset(reset),
		.inject_link(inject_link),
		.inject_ready(inject_ready),
		.eject_link(eject_link),
		.eject_ready(eject_ready)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// valid and ready together before an edge mean one delivered flit
	always @(negedge clk)
	begin
		for (int n = 0; n < num_nodes; n++)
		begin
			if (!reset && eject_link[n].valid && eject_ready[n])
			begin
				got_flit.push_back(eject_link[n].flit);
				got_node.push_back(n);
				got_cycle.push_back(cycle);
			end
		end
	end

	// offer sent[n] on every node in mask and hold each until accepted
	task automatic inject_flits(input logic [num_nodes-1:0] mask);
		logic [num_nodes-1:0] pending;
		logic [num_nodes-1:0] taken;
		pending = mask;
		for (int n = 0; n < num_nodes; n++)
			if (mask[n])
				inject_link[n] = '{valid: 1'b1, flit: sent[n]};
		for (int w = 0; w < 50 && pending != '0; w++)
		begin
			@(negedge clk);
			taken = pending & inject_ready;
			@(posedge clk);
			#2;
			for (int n = 0; n < num_nodes; n++)
			begin
				if (taken[n])
				begin
					inject_link[n].valid = 1'b0;
					accept_cycle[n] = cycle;
				end
			end
			pending = pending & ~taken;
		end
		if (pending != '0)
		begin
			fail_count++;
			$display("inject was never accepted on nodes %b", pending);
		end
	endtask

	// match deliveries to senders by source, then check node, flit and latency
	task automatic score_deliveries(input logic [num_nodes-1:0] mask, input bit check_timing);
		logic [num_nodes-1:0] outstanding;
		int src;
		outstanding = mask;
		for (int w = 0; w < 200 && got_flit.size() < $countones(mask); w++)
		begin
			@(posedge clk);
			#2;
		end
		// late duplicates would show up here
		repeat (4) @(posedge clk);
		#2;
		foreach (got_flit[g])
		begin
			src = got_flit[g].src;
			if (src >= num_nodes || !outstanding[src])
			begin
				fail_count++;
				$display("unexpected or repeated flit from node %0d ejected at node %0d",
					src, got_node[g]);
			end
			else
			begin
				outstanding[src] = 1'b0;
				compare_count(got_node[g], sent[src].dest, "eject node");
				compare_flit(got_flit[g], sent[src], "ejected flit");
				if (check_timing)
					compare_count(got_cycle[g],
						accept_cycle[src] + 2 * hop_count(src, sent[src].dest) + 1, "eject edge");
			end
		end
		if (outstanding != '0)
		begin
			fail_count++;
			$display("flits from nodes %b never arrived", outstanding);
		end
		got_flit.delete();
		got_node.delete();
		got_cycle.delete();
	endtask

	task automatic check_reset_state();
		int valids;
		valids = 0;
		for (int n = 0; n < num_nodes; n++)
			valids += eject_link[n].valid;
		compare_count(inject_ready, {num_nodes{1'b1}}, "inject_ready after reset");
		compare_count(valids, 0, "eject valids after reset");
	endtask

	// one flit at a time from node 0 on an idle network
	task automatic single_routes();
		for (int d = 1; d < num_nodes; d++)
		begin
			sent[0] = '{dest: node_addr_t'(d), src: '0, payload: random_payload()};
			inject_flits(1);
			score_deliveries(1, 1'b1);
		end
	endtask

	// every node sends to the node k steps clockwise, all at once
	task automatic shift_traffic(input int k, input bit check_timing);
		for (int n = 0; n < num_nodes; n++)
			sent[n] = '{dest: node_addr_t'((n + k) % num_nodes), src: node_addr_t'(n),
				payload: random_payload()};
		inject_flits('1);
		score_deliveries('1, check_timing);
	endtask

	// senders in mask all target node d while its eject is held off
	task automatic eject_backpressure(input int d, input logic [num_nodes-1:0] mask);
		flit_t held;
		bit seen;
		seen = 1'b0;
		eject_ready[d] = 1'b0;
		for (int n = 0; n < num_nodes; n++)
			sent[n] = '{dest: node_addr_t'(d), src: node_addr_t'(n), payload: random_payload()};
		inject_flits(mask);
		repeat (30)
		begin
			@(negedge clk);
			if (seen && !eject_link[d].valid)
			begin
				fail_count++;
				$display("eject valid at node %0d dropped while eject_ready was low", d);
			end
			else if (seen)
				compare_flit(eject_link[d].flit, held, "stalled eject flit");
			else if (eject_link[d].valid)
			begin
				held = eject_link[d].flit;
				seen = 1'b1;
			end
		end
		if (!seen)
		begin
			fail_count++;
			$display("no flit reached the stalled eject at node %0d", d);
		end
		compare_count(got_flit.size(), 0, "deliveries while stalled");
		@(posedge clk);
		#2;
		eject_ready[d] = 1'b1;
		score_deliveries(mask, 1'b0);
	endtask

	initial
	begin
		reset = 1'b1;
		inject_link = '0;
		eject_ready = '1;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		check_reset_state();
		single_routes();
		// self-addressed flits on every node
		shift_traffic(0, 1'b1);
		for (int k = 1; k < num_nodes; k++)
			shift_traffic(k, 1'b0);
		eject_backpressure(3, 8'b0110_0011);
		eject_backpressure(6, 8'b1010_0101);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		#(watchdog_cycles * 40);
		$display("timeout: run still going after %0d cycles", watchdog_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tests
hw/spidergon_pkg.sv
hw/output_link.sv
hw/output_arbiter.sv
hw/input_slot.sv
hw/spidergon_router.sv
hw/spidergon_top.sv
tests/spidergon_tb.sv
